// File: hdl/vertex_pkg.sv
`default_nettype none

package vertex_pkg;

   localparam int WORD_BITS   = 32;
   localparam int SLOT_BITS   = 7;
   localparam int TYPE_BITS   = 4;
   localparam int ARGS_BITS   = 64;
   // Memory id carries the core id above the entry id
   localparam int MEM_ID_BITS = 8;
   localparam int CHILD_BITS  = 2;

   typedef logic [WORD_BITS-1:0] word_t;
   typedef logic [SLOT_BITS-1:0] cq_slot_t;
   typedef logic [TYPE_BITS-1:0] task_type_t;

   typedef struct packed {
      task_type_t           ttype;
      word_t                ts;
      word_t                locale;
      logic [ARGS_BITS-1:0] args;
   } task_t;

   typedef struct packed {
      word_t lat;
      word_t lon;
   } coord_t;

   // One completion buffer record
   typedef struct packed {
      word_t    vid;
      word_t    f_score;
      word_t    g_score;
      word_t    parent;
      cq_slot_t cq_slot;
   } cb_entry_t;

   localparam task_type_t vertex_task_type = 4'd1;
   localparam task_type_t child_task_type  = 4'd0;

endpackage

`default_nettype wire

// File: hdl/sync_fifo.sv
`default_nettype none
`timescale 1ns/1ps

module sync_fifo #(
   parameter int WIDTH     = 8,
   parameter int LOG_DEPTH = 4
) (
   input  wire                clk,
   input  wire                rstn,
   input  wire                wr_en,
   input  wire                rd_en,
   input  wire  [WIDTH-1:0]   wr_data,
   output logic [WIDTH-1:0]   rd_data,
   output logic               empty,
   output logic               full,
   output logic [LOG_DEPTH:0] count
);

   localparam int DEPTH = 2 ** LOG_DEPTH;

   logic [WIDTH-1:0]     mem [DEPTH];
   logic [LOG_DEPTH-1:0] wr_ptr;
   logic [LOG_DEPTH-1:0] rd_ptr;
   logic                 do_wr;
   logic                 do_rd;

   // Count never exceeds DEPTH, so its top bit means full
   assign empty   = (count == '0);
   assign full    = count[LOG_DEPTH];
   assign do_wr   = wr_en & ~full;
   assign do_rd   = rd_en & ~empty;
   assign rd_data = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (do_wr & ~do_rd) begin
            count <= count + 1'b1;
         end else if (do_rd & ~do_wr) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_data;
      end
   end

endmodule

`default_nettype wire

// File: hdl/entry_table.sv
`default_nettype none
`timescale 1ns/1ps

module entry_table
   import vertex_pkg::*;
#(
   parameter int LOG_CB_SIZE = 4,
   localparam int CB_SIZE = 2 ** LOG_CB_SIZE,
   localparam type cb_id_t = logic [LOG_CB_SIZE-1:0]
) (
   input  wire                     clk,
   input  wire                     rstn,
   input  wire                     alloc_valid,
   input  wire cb_id_t             alloc_id,
   input  wire cb_entry_t          alloc_entry,
   input  wire                     release_valid,
   input  wire cb_id_t             release_id,
   output cb_entry_t [CB_SIZE-1:0] entries,
   output logic [CB_SIZE-1:0]      busy
);

   // A released entry is never the one being allocated in the same cycle
   always_ff @(posedge clk) begin
      if (!rstn) begin
         busy <= '0;
      end else begin
         if (release_valid) begin
            busy[release_id] <= 1'b0;
         end
         if (alloc_valid) begin
            busy[alloc_id] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (alloc_valid) begin
         entries[alloc_id] <= alloc_entry;
      end
   end

endmodule

`default_nettype wire

// File: hdl/task_intake.sv
`default_nettype none
`timescale 1ns/1ps

module task_intake
   import vertex_pkg::*;
#(
   parameter int LOG_CB_SIZE = 4,
   localparam int CB_SIZE = 2 ** LOG_CB_SIZE,
   localparam type cb_id_t = logic [LOG_CB_SIZE-1:0]
) (
   input  wire                          clk,
   input  wire                          rstn,
   input  wire [CB_SIZE-1:0]            busy,
   input  wire                          task_rvalid,
   input  wire task_t                   task_rdata,
   input  wire cq_slot_t                task_rslot,
   input  wire                          start_ready,
   input  wire cb_entry_t [CB_SIZE-1:0] entries,
   output logic                         task_arvalid,
   output task_type_t                   task_araddr,
   output logic                         alloc_valid,
   output cb_id_t                       alloc_id,
   output cb_entry_t                    alloc_entry,
   output logic                         start_valid,
   output cq_slot_t                     start_slot,
   output logic                         start_id_valid,
   output cb_id_t                       start_id
);

   localparam int START_LOG_DEPTH = 3;
   localparam int START_LIMIT     = 6;

   logic                     running;
   logic                     free_any;
   cb_id_t                   free_id;
   cb_id_t                   head_id;
   logic                     start_empty;
   logic [START_LOG_DEPTH:0] start_count;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         running <= 1'b0;
      end else begin
         running <= 1'b1;
      end
   end

   // Lowest free entry
   always_comb begin
      free_any = 1'b0;
      free_id  = '0;
      for (int i = CB_SIZE - 1; i >= 0; i--) begin
         if (!busy[i]) begin
            free_any = 1'b1;
            free_id  = cb_id_t'(i);
         end
      end
   end

   assign task_araddr  = vertex_task_type;
   assign task_arvalid = running & free_any & (start_count < START_LIMIT);

   assign alloc_valid = task_rvalid & task_arvalid;
   assign alloc_id    = free_id;
   assign alloc_entry = '{vid:     task_rdata.locale,
                          f_score: task_rdata.args[WORD_BITS-1:0],
                          g_score: task_rdata.ts,
                          parent:  task_rdata.args[ARGS_BITS-1:WORD_BITS],
                          cq_slot: task_rslot};

   sync_fifo #(
      .WIDTH     (LOG_CB_SIZE),
      .LOG_DEPTH (START_LOG_DEPTH)
   ) start_fifo (
      .clk     (clk),
      .rstn    (rstn),
      .wr_en   (alloc_valid),
      .rd_en   (start_id_valid),
      .wr_data (free_id),
      .rd_data (head_id),
      .empty   (start_empty),
      .full    (),
      .count   (start_count)
   );

   assign start_valid    = ~start_empty;
   assign start_slot     = entries[head_id].cq_slot;
   assign start_id_valid = start_valid & start_ready;
   assign start_id       = head_id;

endmodule

`default_nettype wire

// File: hdl/coord_fetch.sv
`default_nettype none
`timescale 1ns/1ps

module coord_fetch
   import vertex_pkg::*;
#(
   parameter int CORE_ID     = 0,
   parameter int LOG_CB_SIZE = 4,
   localparam int CB_SIZE = 2 ** LOG_CB_SIZE,
   localparam type cb_id_t = logic [LOG_CB_SIZE-1:0]
) (
   input  wire                          clk,
   input  wire                          rstn,
   input  wire                          start_id_valid,
   input  wire cb_id_t                  start_id,
   input  wire cb_entry_t [CB_SIZE-1:0] entries,
   input  wire word_t                   base_addr,
   input  wire                          mem_arready,
   output logic                         mem_arvalid,
   output word_t                        mem_araddr,
   output logic [MEM_ID_BITS-1:0]       mem_arid
);

   localparam logic [MEM_ID_BITS-1:0] CORE_TAG = MEM_ID_BITS'(CORE_ID) << LOG_CB_SIZE;

   cb_id_t head_id;
   logic   fifo_empty;

   // As deep as the buffer, so a start strobe always finds room
   sync_fifo #(
      .WIDTH     (LOG_CB_SIZE),
      .LOG_DEPTH (LOG_CB_SIZE)
   ) read_fifo (
      .clk     (clk),
      .rstn    (rstn),
      .wr_en   (start_id_valid),
      .rd_en   (mem_arvalid & mem_arready),
      .wr_data (start_id),
      .rd_data (head_id),
      .empty   (fifo_empty),
      .full    (),
      .count   ()
   );

   // Each vertex record is 8 bytes of lat and lon
   assign mem_arvalid = ~fifo_empty;
   assign mem_araddr  = base_addr + (entries[head_id].vid << 3);
   assign mem_arid    = CORE_TAG | MEM_ID_BITS'(head_id);

endmodule

`default_nettype wire

// File: hdl/dist_pipe.sv
`default_nettype none
`timescale 1ns/1ps

module dist_pipe
   import vertex_pkg::*;
#(
   parameter int LOG_CB_SIZE = 4,
   localparam type cb_id_t = logic [LOG_CB_SIZE-1:0]
) (
   input  wire                   clk,
   input  wire                   rstn,
   input  wire                   mem_rvalid,
   input  wire [MEM_ID_BITS-1:0] mem_rid,
   input  wire coord_t           mem_rdata,
   input  wire coord_t           target,
   output logic                  dist_valid,
   output cb_id_t                dist_id,
   output word_t                 dist_value
);

   word_t  dlat;
   word_t  dlon;
   logic   s1_valid;
   cb_id_t s1_id;
   word_t  s1_dlat;
   word_t  s1_dlon;
   logic   s2_valid;
   cb_id_t s2_id;
   word_t  s2_sum;

   // Coordinates are signed, the difference wraps modulo 2^32
   assign dlat = ($signed(mem_rdata.lat) >= $signed(target.lat)) ?
                 mem_rdata.lat - target.lat : target.lat - mem_rdata.lat;
   assign dlon = ($signed(mem_rdata.lon) >= $signed(target.lon)) ?
                 mem_rdata.lon - target.lon : target.lon - mem_rdata.lon;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         s1_valid   <= 1'b0;
         s2_valid   <= 1'b0;
         dist_valid <= 1'b0;
      end else begin
         s1_valid   <= mem_rvalid;
         s2_valid   <= s1_valid;
         dist_valid <= s2_valid;
      end
   end

   always_ff @(posedge clk) begin
      s1_id      <= mem_rid[LOG_CB_SIZE-1:0];
      s1_dlat    <= dlat;
      s1_dlon    <= dlon;
      s2_id      <= s1_id;
      s2_sum     <= s1_dlat + s1_dlon;
      dist_id    <= s2_id;
      dist_value <= s2_sum;
   end

endmodule

`default_nettype wire

// File: hdl/child_enqueue.sv
`default_nettype none
`timescale 1ns/1ps

module child_enqueue
   import vertex_pkg::*;
#(
   parameter int LOG_CB_SIZE = 4,
   localparam int CB_SIZE = 2 ** LOG_CB_SIZE,
   localparam type cb_id_t = logic [LOG_CB_SIZE-1:0]
) (
   input  wire                          clk,
   input  wire                          rstn,
   input  wire                          dist_valid,
   input  wire cb_id_t                  dist_id,
   input  wire word_t                   dist_value,
   input  wire cb_entry_t [CB_SIZE-1:0] entries,
   input  wire                          task_wready,
   input  wire                          finish_ready,
   output logic                         task_wvalid,
   output task_t                        task_wdata,
   output logic                         finish_valid,
   output cq_slot_t                     finish_slot,
   output logic [CHILD_BITS-1:0]        finish_num_children,
   output logic                         release_valid,
   output cb_id_t                       release_id
);

   typedef struct packed {
      cb_id_t id;
      word_t  f_sum;
   } done_t;

   done_t     done_in;
   done_t     done_head;
   logic      done_empty;
   cb_entry_t parent;
   logic      fin_pending;
   cb_id_t    fin_id;

   assign done_in.id    = dist_id;
   assign done_in.f_sum = entries[dist_id].f_score + dist_value;

   sync_fifo #(
      .WIDTH     ($bits(done_t)),
      .LOG_DEPTH (LOG_CB_SIZE)
   ) done_fifo (
      .clk     (clk),
      .rstn    (rstn),
      .wr_en   (dist_valid),
      .rd_en   (task_wvalid & task_wready),
      .wr_data (done_in),
      .rd_data (done_head),
      .empty   (done_empty),
      .full    (),
      .count   ()
   );

   assign parent = entries[done_head.id];

   // Only one parent may wait for its finish report
   assign task_wvalid       = ~done_empty & ~fin_pending;
   assign task_wdata.ttype  = child_task_type;
   assign task_wdata.ts     = (parent.g_score > done_head.f_sum) ? parent.g_score
                                                                 : done_head.f_sum;
   assign task_wdata.locale = parent.vid;
   assign task_wdata.args   = {parent.parent, parent.f_score};

   always_ff @(posedge clk) begin
      if (!rstn) begin
         fin_pending <= 1'b0;
      end else if (finish_valid & finish_ready) begin
         fin_pending <= 1'b0;
      end else if (task_wvalid & task_wready) begin
         fin_pending <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (task_wvalid & task_wready) begin
         fin_id <= done_head.id;
      end
   end

   assign finish_valid        = fin_pending;
   assign finish_slot         = entries[fin_id].cq_slot;
   assign finish_num_children = CHILD_BITS'(1);
   assign release_valid       = finish_valid & finish_ready;
   assign release_id          = fin_id;

endmodule

`default_nettype wire

// File: hdl/vertex_core.sv
`default_nettype none
`timescale 1ns/1ps

module vertex_core
   import vertex_pkg::*;
#(
   parameter int CORE_ID     = 0,
   parameter int LOG_CB_SIZE = 4,
   localparam int CB_SIZE = 2 ** LOG_CB_SIZE,
   localparam type cb_id_t = logic [LOG_CB_SIZE-1:0]
) (
   input  wire                    clk,
   input  wire                    rstn,
   // Held stable after reset
   input  wire word_t             base_addr,
   input  wire coord_t            target,
   output logic                   task_arvalid,
   output task_type_t             task_araddr,
   input  wire                    task_rvalid,
   input  wire task_t             task_rdata,
   input  wire cq_slot_t          task_rslot,
   output logic                   start_valid,
   input  wire                    start_ready,
   output cq_slot_t               start_slot,
   output logic                   mem_arvalid,
   input  wire                    mem_arready,
   output word_t                  mem_araddr,
   output logic [MEM_ID_BITS-1:0] mem_arid,
   input  wire                    mem_rvalid,
   input  wire [MEM_ID_BITS-1:0]  mem_rid,
   input  wire coord_t            mem_rdata,
   output logic                   task_wvalid,
   input  wire                    task_wready,
   output task_t                  task_wdata,
   output logic                   finish_valid,
   input  wire                    finish_ready,
   output cq_slot_t               finish_slot,
   output logic [CHILD_BITS-1:0]  finish_num_children
);

   logic                    alloc_valid;
   cb_id_t                  alloc_id;
   cb_entry_t               alloc_entry;
   logic                    release_valid;
   cb_id_t                  release_id;
   cb_entry_t [CB_SIZE-1:0] entries;
   logic [CB_SIZE-1:0]      busy;
   logic                    start_id_valid;
   cb_id_t                  start_id;
   logic                    dist_valid;
   cb_id_t                  dist_id;
   word_t                   dist_value;

   entry_table #(.LOG_CB_SIZE(LOG_CB_SIZE)) entry_table_inst (
      .clk           (clk),
      .rstn          (rstn),
      .alloc_valid   (alloc_valid),
      .alloc_id      (alloc_id),
      .alloc_entry   (alloc_entry),
      .release_valid (release_valid),
      .release_id    (release_id),
      .entries       (entries),
      .busy          (busy)
   );

   task_intake #(.LOG_CB_SIZE(LOG_CB_SIZE)) task_intake_inst (
      .clk            (clk),
      .rstn           (rstn),
      .busy           (busy),
      .task_rvalid    (task_rvalid),
      .task_rdata     (task_rdata),
      .task_rslot     (task_rslot),
      .start_ready    (start_ready),
      .entries        (entries),
      .task_arvalid   (task_arvalid),
      .task_araddr    (task_araddr),
      .alloc_valid    (alloc_valid),
      .alloc_id       (alloc_id),
      .alloc_entry    (alloc_entry),
      .start_valid    (start_valid),
      .start_slot     (start_slot),
      .start_id_valid (start_id_valid),
      .start_id       (start_id)
   );

   coord_fetch #(
      .CORE_ID     (CORE_ID),
      .LOG_CB_SIZE (LOG_CB_SIZE)
   ) coord_fetch_inst (
      .clk            (clk),
      .rstn           (rstn),
      .start_id_valid (start_id_valid),
      .start_id       (start_id),
      .entries        (entries),
      .base_addr      (base_addr),
      .mem_arready    (mem_arready),
      .mem_arvalid    (mem_arvalid),
      .mem_araddr     (mem_araddr),
      .mem_arid       (mem_arid)
   );

   dist_pipe #(.LOG_CB_SIZE(LOG_CB_SIZE)) dist_pipe_inst (
      .clk        (clk),
      .rstn       (rstn),
      .mem_rvalid (mem_rvalid),
      .mem_rid    (mem_rid),
      .mem_rdata  (mem_rdata),
      .target     (target),
      .dist_valid (dist_valid),
      .dist_id    (dist_id),
      .dist_value (dist_value)
   );

   child_enqueue #(.LOG_CB_SIZE(LOG_CB_SIZE)) child_enqueue_inst (
      .clk                 (clk),
      .rstn                (rstn),
      .dist_valid          (dist_valid),
      .dist_id             (dist_id),
      .dist_value          (dist_value),
      .entries             (entries),
      .task_wready         (task_wready),
      .finish_ready        (finish_ready),
      .task_wvalid         (task_wvalid),
      .task_wdata          (task_wdata),
      .finish_valid        (finish_valid),
      .finish_slot         (finish_slot),
      .finish_num_children (finish_num_children),
      .release_valid       (release_valid),
      .release_id          (release_id)
   );

endmodule

`default_nettype wire

// File: sim/tb_vertex_core.sv
`default_nettype none
`timescale 1ns/1ps

module tb_vertex_core
   import vertex_pkg::*;
();

   localparam int CORE_ID     = 3;
   localparam int LOG_CB_SIZE = 4;
   localparam int CB_SIZE     = 2 ** LOG_CB_SIZE;
   localparam int MAX_TASKS   = 32;
   localparam int MAX_VIDS    = 16;

   logic                   clk;
   logic                   rstn;
   word_t                  base_addr;
   coord_t                 target;
   logic                   task_arvalid;
   task_type_t             task_araddr;
   logic                   task_rvalid;
   task_t                  task_rdata;
   cq_slot_t               task_rslot;
   logic                   start_valid;
   logic                   start_ready;
   cq_slot_t               start_slot;
   logic                   mem_arvalid;
   logic                   mem_arready;
   word_t                  mem_araddr;
   logic [MEM_ID_BITS-1:0] mem_arid;
   logic                   mem_rvalid;
   logic [MEM_ID_BITS-1:0] mem_rid;
   coord_t                 mem_rdata;
   logic                   task_wvalid;
   logic                   task_wready;
   task_t                  task_wdata;
   logic                   finish_valid;
   logic                   finish_ready;
   cq_slot_t               finish_slot;
   logic [CHILD_BITS-1:0]  finish_num_children;

   // Vertex coordinates and the task list from the vectors file
   coord_t coords [MAX_VIDS];
   word_t  t_slot [MAX_TASKS];
   word_t  t_ts   [MAX_TASKS];
   word_t  t_vid  [MAX_TASKS];
   word_t  t_f    [MAX_TASKS];
   word_t  t_par  [MAX_TASKS];
   word_t  t_exp  [MAX_TASKS];
   int     num_tasks;

   int       offer_idx [$];
   int       offer_pass [$];
   int       cur_idx;
   int       cur_pass;
   cq_slot_t exp_start [$];
   cq_slot_t exp_parent [$];
   task_t    exp_child [$];
   word_t    exp_addr [$];
   cq_slot_t last_slot;
   logic     child_waiting;

   // Memory model request queue, answered in order
   word_t                  req_addr [$];
   logic [MEM_ID_BITS-1:0] req_id [$];
   int                     req_due [$];

   int   cycles;
   int   cycle_limit;
   int   dequeued;
   int   children;
   int   finished;
   int   value_errors;
   int   other_errors;
   logic rand_mode;
   logic hold_finish;
   logic checked_after_reset;

   vertex_core #(
      .CORE_ID     (CORE_ID),
      .LOG_CB_SIZE (LOG_CB_SIZE)
   ) vertex_core_inst (
      .clk                 (clk),
      .rstn                (rstn),
      .base_addr           (base_addr),
      .target              (target),
      .task_arvalid        (task_arvalid),
      .task_araddr         (task_araddr),
      .task_rvalid         (task_rvalid),
      .task_rdata          (task_rdata),
      .task_rslot          (task_rslot),
      .start_valid         (start_valid),
      .start_ready         (start_ready),
      .start_slot          (start_slot),
      .mem_arvalid         (mem_arvalid),
      .mem_arready         (mem_arready),
      .mem_araddr          (mem_araddr),
      .mem_arid            (mem_arid),
      .mem_rvalid          (mem_rvalid),
      .mem_rid             (mem_rid),
      .mem_rdata           (mem_rdata),
      .task_wvalid         (task_wvalid),
      .task_wready         (task_wready),
      .task_wdata          (task_wdata),
      .finish_valid        (finish_valid),
      .finish_ready        (finish_ready),
      .finish_slot         (finish_slot),
      .finish_num_children (finish_num_children)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic check_task(input task_t got, input task_t exp, input string what);
      if (got !== exp) begin
         value_errors++;
         $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_slot(input cq_slot_t got, input cq_slot_t exp, input string what);
      if (got !== exp) begin
         value_errors++;
         $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_word(input word_t got, input word_t exp, input string what);
      if (got !== exp) begin
         value_errors++;
         $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   // Later passes shift the slot so repeated tasks stay distinguishable
   function automatic cq_slot_t slot_of(input int idx, input int pass);
      return cq_slot_t'(t_slot[idx] + word_t'(pass * 32));
   endfunction

   task automatic load_vectors();
      int    fd;
      string line;
      word_t a;
      word_t b;
      word_t c;
      word_t d;
      word_t e;
      word_t g;
      for (int i = 0; i < MAX_VIDS; i++) begin
         coords[i] = '{lat: 32'h5a00_0000 ^ word_t'(i), lon: ~word_t'(i)};
      end
      fd = $fopen("sim/vertex_vectors.txt", "r");
      if (fd == 0) begin
         other_errors++;
         $display("Could not open sim/vertex_vectors.txt");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ($sscanf(line, "C %h %h %h", a, b, c) == 3) begin
               coords[a[3:0]] = '{lat: b, lon: c};
            end else if ($sscanf(line, "G %h %h %h", a, b, c) == 3) begin
               target    = '{lat: a, lon: b};
               base_addr = c;
            end else if ($sscanf(line, "T %h %h %h %h %h %h", a, b, c, d, e, g) == 6) begin
               t_slot[num_tasks] = a;
               t_ts[num_tasks]   = b;
               t_vid[num_tasks]  = c;
               t_f[num_tasks]    = d;
               t_par[num_tasks]  = e;
               t_exp[num_tasks]  = g;
               num_tasks++;
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic queue_tasks(input int pass);
      for (int i = 0; i < num_tasks; i++) begin
         offer_idx.push_back(i);
         offer_pass.push_back(pass);
      end
   endtask

   task automatic wait_for_finishes(input int n);
      while (finished < n) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic observe_transfers();
      task_t exp_task;
      check_word(32'(task_araddr), 32'd1, "task_araddr");
      if (task_rvalid && task_arvalid) begin
         dequeued++;
         exp_start.push_back(slot_of(cur_idx, cur_pass));
         exp_parent.push_back(slot_of(cur_idx, cur_pass));
         // Vertex records are 8 bytes apart
         exp_addr.push_back(base_addr + 32'd8 * t_vid[cur_idx]);
         exp_task = '{ttype: 4'd0, ts: t_exp[cur_idx], locale: t_vid[cur_idx],
                      args: {t_par[cur_idx], t_f[cur_idx]}};
         exp_child.push_back(exp_task);
      end
      if (start_valid && start_ready) begin
         if (exp_start.size() == 0) begin
            other_errors++;
            $display("Start report seen with no dequeued task waiting for it");
         end else begin
            check_slot(start_slot, exp_start.pop_front(), "start_slot");
         end
      end
      if (mem_arvalid && mem_arready) begin
         check_word(32'(mem_arid >> LOG_CB_SIZE), word_t'(CORE_ID), "mem_arid core id");
         if (exp_addr.size() == 0) begin
            other_errors++;
            $display("Memory read issued with no started task waiting for it");
         end else begin
            check_word(mem_araddr, exp_addr.pop_front(), "mem_araddr");
         end
         req_addr.push_back(mem_araddr);
         req_id.push_back(mem_arid);
         req_due.push_back(cycles + 1 + int'($urandom() % 4));
      end
      if (finish_valid && finish_ready) begin
         if (!child_waiting) begin
            other_errors++;
            $display("Finish report seen without an enqueued child before it");
         end else begin
            check_slot(finish_slot, last_slot, "finish_slot");
            check_word(32'(finish_num_children), 32'd1, "finish_num_children");
         end
         child_waiting = 1'b0;
         finished++;
      end
      if (task_wvalid && task_wready) begin
         if (exp_child.size() == 0) begin
            other_errors++;
            $display("Child enqueued with no dequeued task waiting for it");
         end else begin
            check_task(task_wdata, exp_child.pop_front(), "child task");
            last_slot = exp_parent.pop_front();
         end
         if (child_waiting) begin
            other_errors++;
            $display("Child enqueued while the previous finish was still pending");
         end
         child_waiting = 1'b1;
         children++;
      end
   endtask

   // Input driver, 1 ns after the rising edge
   always @(posedge clk) begin
      #1;
      start_ready  = !rand_mode || ($urandom() % 3 != 0);
      mem_arready  = !rand_mode || ($urandom() % 3 != 0);
      task_wready  = !rand_mode || ($urandom() % 3 != 0);
      finish_ready = !hold_finish && (!rand_mode || ($urandom() % 3 != 0));
      task_rvalid  = 1'b0;
      if (task_arvalid && offer_idx.size() > 0 && ($urandom() % 4 != 0)) begin
         cur_idx     = offer_idx.pop_front();
         cur_pass    = offer_pass.pop_front();
         task_rvalid = 1'b1;
         task_rslot  = slot_of(cur_idx, cur_pass);
         task_rdata  = '{ttype: 4'd1, ts: t_ts[cur_idx], locale: t_vid[cur_idx],
                         args: {t_par[cur_idx], t_f[cur_idx]}};
      end
      mem_rvalid = 1'b0;
      if (req_due.size() > 0 && req_due[0] <= cycles) begin
         mem_rvalid = 1'b1;
         mem_rid    = req_id.pop_front();
         mem_rdata  = coords[4'((req_addr.pop_front() - base_addr) >> 3)];
         void'(req_due.pop_front());
      end
   end

   // Monitor, samples on the rising edge
   always @(posedge clk) begin
      cycles++;
      if (cycles >= cycle_limit) begin
         $display("Timeout: the run did not complete within %0d cycles", cycle_limit);
         $display("TESTBENCH FAILED");
         $finish;
      end else if (!rstn || !checked_after_reset) begin
         check_word(32'({task_arvalid, start_valid, mem_arvalid, task_wvalid, finish_valid}),
                    32'd0, "valid outputs around reset");
         if (rstn) begin
            checked_after_reset = 1'b1;
         end
      end else begin
         observe_transfers();
      end
   end

   initial begin
      rstn                = 1'b0;
      base_addr           = '0;
      target              = '0;
      task_rvalid         = 1'b0;
      task_rdata          = '0;
      task_rslot          = '0;
      start_ready         = 1'b0;
      mem_arready         = 1'b0;
      mem_rvalid          = 1'b0;
      mem_rid             = '0;
      mem_rdata           = '0;
      task_wready         = 1'b0;
      finish_ready        = 1'b0;
      rand_mode           = 1'b1;
      hold_finish         = 1'b0;
      checked_after_reset = 1'b0;
      child_waiting       = 1'b0;
      last_slot           = '0;
      cur_idx             = 0;
      cur_pass            = 0;
      num_tasks           = 0;
      cycles              = 0;
      dequeued            = 0;
      children            = 0;
      finished            = 0;
      value_errors        = 0;
      other_errors        = 0;
      cycle_limit         = 1000;
      void'($urandom(32'h7b58_afe2));
      load_vectors();
      // Three passes over the task list
      cycle_limit = 200 * 3 * num_tasks + 500;
      repeat (2) @(posedge clk);
      #1;
      rstn = 1'b1;
      if (num_tasks == 0) begin
         other_errors++;
         $display("No tasks were read from the vectors file");
      end else begin
         queue_tasks(0);
         wait_for_finishes(num_tasks);
         // Fill the buffer while no finish is accepted
         rand_mode   = 1'b0;
         hold_finish = 1'b1;
         queue_tasks(1);
         queue_tasks(2);
         while (dequeued - finished < CB_SIZE) begin
            @(posedge clk);
            #1;
         end
         repeat (10) @(posedge clk);
         #1;
         check_word(32'(task_arvalid), 32'd0, "task_arvalid with a full buffer");
         check_word(word_t'(dequeued - finished), word_t'(CB_SIZE), "tasks in the buffer");
         hold_finish = 1'b0;
         rand_mode   = 1'b1;
         wait_for_finishes(3 * num_tasks);
         repeat (5) @(posedge clk);
         #1;
         check_word(word_t'(dequeued), word_t'(3 * num_tasks), "dequeued task count");
         check_word(word_t'(children), word_t'(3 * num_tasks), "child count");
         check_word(word_t'(finished), word_t'(3 * num_tasks), "finish count");
      end
      $display("Checks done with %0d value errors and %0d other errors",
               value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sim/vertex_vectors.txt
# C vid lat lon | G target_lat target_lon base_addr (hex, coordinates signed)
# T slot ts vid f_score parent expected_child_ts (hex)
C 0 00000064 000000c8
C 1 00000070 000000b4
C 2 fffffff6 0000012c
C 3 000003e8 ffffff9c
C 4 00000050 000000c8
C 5 ffffff38 fffffe70
G 00000064 000000c8 00001000
T 01 00000010 1 00000005 0000000a 00000025
T 02 00000100 2 00000010 0000000b 00000100
T 03 00000000 3 00000000 0000000c 000004b0
T 04 00000050 0 00000050 0000000d 00000050
T 05 00000200 4 00000300 0000000e 00000314
T 06 00001000 5 00000001 0000000f 00001000
T 07 00000003 1 00000007 00000010 00000027
T 08 fffffff0 2 00000000 00000011 fffffff0
T 09 00000000 3 ffffff00 00000012 000003b0
T 0a 00000020 5 00000000 00000013 00000384

// File: tb.f
hdl/vertex_pkg.sv
hdl/sync_fifo.sv
hdl/entry_table.sv
hdl/task_intake.sv
hdl/coord_fetch.sv
hdl/dist_pipe.sv
hdl/child_enqueue.sv
hdl/vertex_core.sv
sim/tb_vertex_core.sv

// File: run.sh
#!/bin/sh
set -e
verilator --binary -f tb.f --top-module tb_vertex_core -o tb_vertex_core
./obj_dir/tb_vertex_core > sim.log
cat sim.log
if grep -q "TESTBENCH PASSED" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed, see sim.log"
   exit 1
fi
